/* ui_pkg.sv */
package ui_pkg;

	////////////////////////////////////////////////////////////////////////////
	// call states
	////////////////////////////////////////////////////////////////////////////
	typedef enum logic [2:0] {
		idle       = 3'd0,	// no call in progress
		incoming   = 3'd1,	// node is being called
		outgoing   = 3'd2,	// node is calling out
		busy       = 3'd3,	// call connected
		initialize = 3'd5	// waiting for network init, code 4 stays free
	} call_state_t;

	////////////////////////////////////////////////////////////////////////////
	// menu items, codes match the display firmware
	////////////////////////////////////////////////////////////////////////////
	typedef enum logic [5:0] {
		call_number  = 6'd0,	// main menu ring
		volume       = 6'd1,
		get_num      = 6'd3,
		set_time     = 6'd4,
		dialing      = 6'd7,	// switches are the called address
		change_vol   = 6'd8,	// pending volume shown here
		def_incoming = 6'd32,	// incoming ring
		accept       = 6'd33,
		reject       = 6'd34,
		def_outgoing = 6'd36,	// outgoing toggle pair
		end_call     = 6'd37,
		def_busy     = 6'd38,	// busy ring
		end_call_b   = 6'd39,
		set_volume   = 6'd40,
		def_welcome  = 6'd50,	// default screens
		def_init     = 6'd51,
		def_sys      = 6'd53
	} menu_item_t;

	// ui -> application layer
	typedef enum logic [2:0] {
		cmd_init    = 3'd0,
		make_call   = 3'd1,
		stop_call   = 3'd2,
		accept_call = 3'd3
	} ui_cmd_t;

	// application layer -> ui
	typedef enum logic [2:0] {
		sts_none      = 3'd0,
		connected     = 3'd1,
		failed        = 3'd4,	// dropped or never went through
		incoming_call = 3'd5,
		call_ended    = 3'd6
	} app_status_t;

	// one-hot at most, single cycle
	typedef struct packed {
		logic up;
		logic down;
		logic select;	// enter or right
		logic left;
	} key_event_t;

	////////////////////////////////////////////////////////////////////////////
	// text rom
	////////////////////////////////////////////////////////////////////////////
	localparam int TEXT_ADDR_W = 11;

	typedef struct packed {
		logic [TEXT_ADDR_W-1:0] addr;	// first character
		logic [TEXT_ADDR_W-1:0] len;	// characters to scroll
		logic                   has_text;
	} text_ref_t;

	localparam logic [TEXT_ADDR_W-1:0] init_text_addr = 11'd0;	// "press enter..." banner
	localparam logic [TEXT_ADDR_W-1:0] init_text_len = 11'd45;
	localparam text_ref_t no_text = '0;

	function automatic text_ref_t text_entry(input logic [TEXT_ADDR_W-1:0] addr,
			input logic [TEXT_ADDR_W-1:0] len);
		text_entry = '{addr: addr, len: len, has_text: 1'b1};
	endfunction

endpackage

/* key_sampler.sv */
`timescale 1ns/10ps

module key_sampler import ui_pkg::*; #(
	parameter int NUM_W = 8	// switch width of the node
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       enter,
	input  logic       up,
	input  logic       down,
	input  logic       left,
	input  logic       right,
	output key_event_t key_evt
);

	logic [4:0] btn_in;	// 0 up, 1 down, 2 enter, 3 right, 4 left
	logic [4:0] btn_cur;	// sample at edge k
	logic [4:0] btn_prev;	// sample at edge k-1
	logic [4:0] rise;

	assign btn_in = {left, right, enter, down, up};
	assign rise = btn_cur & ~btn_prev;	// low then high, held button counts once

	always_ff @(posedge clk) begin
		if (reset) begin
			btn_cur <= '0;
			btn_prev <= '0;
			key_evt <= '0;
		end else begin
			btn_cur <= btn_in;
			btn_prev <= btn_cur;
			key_evt <= '0;	// pulse by default
			// priority up, down, select, left
			if (rise[0])
				key_evt.up <= 1'b1;
			else if (rise[1])
				key_evt.down <= 1'b1;
			else if (rise[2] || rise[3])	// enter and right are the same key
				key_evt.select <= 1'b1;
			else if (rise[4])
				key_evt.left <= 1'b1;
		end
	end

endmodule

/* call_menu_fsm.sv */
`timescale 1ns/10ps

module call_menu_fsm import ui_pkg::*; #(
	parameter int NUM_W = 8,
	parameter int VOL_W = 5
) (
	input  logic             clk,
	input  logic             reset,
	input  key_event_t       key_evt,
	input  logic [NUM_W-1:0] switches,
	input  app_status_t      inc_command,
	output call_state_t      state,
	output menu_item_t       menu_item,
	output ui_cmd_t          command,
	output logic [NUM_W-1:0] address,
	output logic [VOL_W-1:0] headphone_volume
);

	localparam logic [VOL_W-1:0] vol_max = '1;
	localparam logic [VOL_W-1:0] vol_mid = {1'b1, {(VOL_W-1){1'b0}}};	// 16 at 5 bits

	logic [VOL_W-1:0] vol_pending;	// shown while in change_vol
	logic             any_key;
	menu_item_t       vol_home;	// where the volume screen returns to

	assign any_key = |key_evt;
	assign vol_home = (state == busy) ? set_volume : volume;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= initialize;
			menu_item <= def_init;
			command <= cmd_init;
			address <= '0;
			headphone_volume <= vol_mid;
			vol_pending <= vol_mid;
		end else if (any_key) begin	// keys win over status
			if (menu_item == change_vol) begin
				////////////////////////////////////////////////////////////////////////////
				// volume adjust, shared by idle and busy
				////////////////////////////////////////////////////////////////////////////
				if (key_evt.up && vol_pending != vol_max)
					vol_pending <= vol_pending + 1'b1;	// saturate high
				else if (key_evt.down && vol_pending != '0)
					vol_pending <= vol_pending - 1'b1;	// saturate low
				else if (key_evt.select) begin
					headphone_volume <= vol_pending;	// commit
					menu_item <= vol_home;
				end else if (key_evt.left)
					menu_item <= vol_home;	// discard pending
			end else begin
				case (state)
					initialize: begin
						if (key_evt.select) begin
							state <= idle;
							menu_item <= def_welcome;
						end
					end
					idle: begin
						if (key_evt.up) begin
							case (menu_item)	// ring steps backwards
								call_number: menu_item <= set_time;
								volume:      menu_item <= call_number;
								get_num:     menu_item <= volume;	// voicemail slot hidden
								set_time:    menu_item <= get_num;
								default: ;
							endcase
						end else if (key_evt.down) begin
							case (menu_item)
								call_number: menu_item <= volume;
								volume:      menu_item <= get_num;
								get_num:     menu_item <= set_time;
								set_time:    menu_item <= call_number;
								default: ;
							endcase
						end else if (key_evt.select) begin
							case (menu_item)
								def_welcome, def_sys: menu_item <= call_number;
								call_number: menu_item <= dialing;
								volume: begin
									vol_pending <= headphone_volume;
									menu_item <= change_vol;
								end
								dialing: begin	// place the call
									address <= switches;
									command <= make_call;
									state <= outgoing;
									menu_item <= def_outgoing;
								end
								default: ;	// get_num, set_time have no sub screen
							endcase
						end else begin	// left
							case (menu_item)
								call_number, volume, get_num, set_time: menu_item <= def_sys;
								dialing: menu_item <= call_number;
								default: ;
							endcase
						end
					end
					outgoing: begin
						if (key_evt.up || key_evt.down)	// two items, just toggle
							menu_item <= (menu_item == end_call) ? def_outgoing : end_call;
						else if (key_evt.select && menu_item == end_call)
							command <= stop_call;
					end
					incoming: begin
						if (key_evt.up) begin
							case (menu_item)
								def_incoming: menu_item <= reject;
								accept:       menu_item <= def_incoming;
								reject:       menu_item <= accept;
								default: ;
							endcase
						end else if (key_evt.down) begin
							case (menu_item)
								def_incoming: menu_item <= accept;
								accept:       menu_item <= reject;
								reject:       menu_item <= def_incoming;
								default: ;
							endcase
						end else if (key_evt.select) begin
							case (menu_item)
								def_incoming, accept: command <= accept_call;
								reject: command <= stop_call;
								default: ;
							endcase
						end
					end
					busy: begin
						if (key_evt.up) begin
							case (menu_item)
								def_busy:   menu_item <= set_volume;
								end_call_b: menu_item <= def_busy;
								set_volume: menu_item <= end_call_b;
								default: ;
							endcase
						end else if (key_evt.down) begin
							case (menu_item)
								def_busy:   menu_item <= end_call_b;
								end_call_b: menu_item <= set_volume;
								set_volume: menu_item <= def_busy;
								default: ;
							endcase
						end else if (key_evt.select) begin
							if (menu_item == end_call_b)
								command <= stop_call;
							else if (menu_item == set_volume) begin
								vol_pending <= headphone_volume;
								menu_item <= change_vol;
							end
						end
					end
					default: ;
				endcase
			end
		end else begin
			////////////////////////////////////////////////////////////////////////////
			// application layer status, no key this cycle
			////////////////////////////////////////////////////////////////////////////
			case (state)
				idle: begin
					if (inc_command == incoming_call) begin
						state <= incoming;
						menu_item <= def_incoming;
					end
				end
				outgoing, incoming: begin
					if (inc_command == connected) begin
						state <= busy;
						menu_item <= def_busy;
					end else if (inc_command == call_ended ||
							(inc_command == failed && state == outgoing)) begin
						state <= idle;	// failed only counts while dialing out
						menu_item <= def_sys;
					end
				end
				busy: begin
					if (inc_command == call_ended) begin
						state <= idle;
						menu_item <= def_sys;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

/* menu_text_rom.sv */
`timescale 1ns/10ps

module menu_text_rom import ui_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  menu_item_t             menu_item,
	output logic [TEXT_ADDR_W-1:0] text_addr,
	output logic [TEXT_ADDR_W-1:0] text_len,
	output logic                   text_start	// one cycle, kicks the scroller
);

	menu_item_t item_prev;
	text_ref_t  item_ref;

	// address and length of each screen in the text rom
	function automatic text_ref_t text_lookup(input menu_item_t item);
		case (item)
			def_init:             text_lookup = text_entry(init_text_addr, init_text_len);
			def_welcome:          text_lookup = text_entry(11'd72, 11'd7);	// welcome
			call_number:          text_lookup = text_entry(11'd80, 11'd11);
			volume, set_volume:   text_lookup = text_entry(11'd92, 11'd20);
			set_time:             text_lookup = text_entry(11'd452, 11'd15);
			get_num:              text_lookup = text_entry(11'd468, 11'd21);
			def_incoming:         text_lookup = text_entry(11'd361, 11'd13);
			accept:               text_lookup = text_entry(11'd375, 11'd20);
			reject:               text_lookup = text_entry(11'd396, 11'd20);
			def_outgoing:         text_lookup = text_entry(11'd435, 11'd7);	// calling
			end_call, end_call_b: text_lookup = text_entry(11'd443, 11'd8);	// shared string
			def_busy:             text_lookup = text_entry(11'd490, 11'd12);
			default:              text_lookup = no_text;	// dialing, change_vol, def_sys
		endcase
	endfunction

	assign item_ref = text_lookup(menu_item);

	////////////////////////////////////////////////////////////////////////////
	// load on change, screens without text keep the old string
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			item_prev <= def_init;	// matches fsm reset, so no pulse
			text_addr <= init_text_addr;
			text_len <= init_text_len;
			text_start <= 1'b0;
		end else begin
			item_prev <= menu_item;
			text_start <= 1'b0;
			if (menu_item != item_prev && item_ref.has_text) begin
				text_addr <= item_ref.addr;
				text_len <= item_ref.len;
				text_start <= 1'b1;
			end
		end
	end

endmodule

/* user_interface.sv */
`timescale 1ns/10ps

module user_interface import ui_pkg::*; #(
	parameter int NUM_W = 8,	// switch and address width
	parameter int VOL_W = 5	// headphone volume width
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   enter,
	input  logic                   up,
	input  logic                   down,
	input  logic                   left,
	input  logic                   right,
	input  logic [NUM_W-1:0]       switches,
	input  app_status_t            inc_command,
	output call_state_t            current_state,
	output menu_item_t             current_menu_item,
	output ui_cmd_t                command,
	output logic [NUM_W-1:0]       address,
	output logic [VOL_W-1:0]       headphone_volume,
	output logic [TEXT_ADDR_W-1:0] text_addr,
	output logic [TEXT_ADDR_W-1:0] text_len,
	output logic                   text_start
);

	key_event_t key_evt;	// stage 1 -> 2

	key_sampler #(.NUM_W(NUM_W)) u_key_sampler (
		.clk(clk), .reset(reset), .enter(enter), .up(up), .down(down),
		.left(left), .right(right), .key_evt(key_evt)
	);

	call_menu_fsm #(.NUM_W(NUM_W), .VOL_W(VOL_W)) u_call_menu_fsm (
		.clk(clk), .reset(reset), .key_evt(key_evt), .switches(switches),
		.inc_command(inc_command), .state(current_state), .menu_item(current_menu_item),
		.command(command), .address(address), .headphone_volume(headphone_volume)
	);

	// stage 3 reads the menu item straight off the output
	menu_text_rom u_menu_text_rom (
		.clk(clk), .reset(reset), .menu_item(current_menu_item),
		.text_addr(text_addr), .text_len(text_len), .text_start(text_start)
	);

endmodule

/* ui_checker.sv */
`timescale 1ns/10ps

module ui_checker import ui_pkg::*; #(
	parameter int NUM_W = 8,
	parameter int VOL_W = 5
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [4:0]             buttons,	// left, right, enter, down, up
	input  logic [NUM_W-1:0]       switches,
	input  app_status_t            inc_command,
	input  call_state_t            current_state,
	input  menu_item_t             current_menu_item,
	input  ui_cmd_t                command,
	input  logic [NUM_W-1:0]       address,
	input  logic [VOL_W-1:0]       headphone_volume,
	input  logic [TEXT_ADDR_W-1:0] text_addr,
	input  logic [TEXT_ADDR_W-1:0] text_len,
	input  logic                   text_start,
	output int                     value_errors
);

	localparam logic [VOL_W-1:0] vol_mid = 1 << (VOL_W - 1);

	typedef struct packed {
		call_state_t      st;
		menu_item_t       item;
		ui_cmd_t          cmd;
		logic [NUM_W-1:0] addr;
		logic [VOL_W-1:0] vol;	// committed
		logic [VOL_W-1:0] pend;	// while adjusting
	} model_t;

	model_t                 m;
	key_event_t             evt;	// modelled stage 1 output
	logic [4:0]             cur;
	logic [4:0]             prev;
	logic [4:0]             rise;
	menu_item_t             t_prev;
	text_ref_t              t;
	logic [TEXT_ADDR_W-1:0] exp_addr;
	logic [TEXT_ADDR_W-1:0] exp_len;
	logic                   exp_start;

	initial value_errors = 0;

	// text table, straight from the screen list
	function automatic text_ref_t expected_text(input menu_item_t item);
		case (item)
			def_init:             expected_text = {11'd0, 11'd45, 1'b1};
			def_welcome:          expected_text = {11'd72, 11'd7, 1'b1};
			call_number:          expected_text = {11'd80, 11'd11, 1'b1};
			volume, set_volume:   expected_text = {11'd92, 11'd20, 1'b1};
			set_time:             expected_text = {11'd452, 11'd15, 1'b1};
			get_num:              expected_text = {11'd468, 11'd21, 1'b1};
			def_incoming:         expected_text = {11'd361, 11'd13, 1'b1};
			accept:               expected_text = {11'd375, 11'd20, 1'b1};
			reject:               expected_text = {11'd396, 11'd20, 1'b1};
			def_outgoing:         expected_text = {11'd435, 11'd7, 1'b1};
			end_call, end_call_b: expected_text = {11'd443, 11'd8, 1'b1};
			def_busy:             expected_text = {11'd490, 11'd12, 1'b1};
			default:              expected_text = '0;	// silent screens
		endcase
	endfunction

	// one step around a ring of n items, down is forward
	function automatic menu_item_t rotate(input menu_item_t item, input logic fwd, input int n,
			input menu_item_t r0, input menu_item_t r1, input menu_item_t r2, input menu_item_t r3);
		menu_item_t r [4];
		r[0] = r0;
		r[1] = r1;
		r[2] = r2;
		r[3] = r3;
		for (int i = 0; i < n; i++)
			if (r[i] == item)
				return r[fwd ? (i + 1) % n : (i + n - 1) % n];
		return item;	// not on this ring
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// reference model, one clock of stage 2
	////////////////////////////////////////////////////////////////////////////
	function automatic model_t step(input model_t s, input key_event_t k, input app_status_t a,
			input logic [NUM_W-1:0] sw);
		model_t     n;
		menu_item_t home;
		n = s;
		home = (s.st == busy) ? set_volume : volume;
		if (|k && s.item == change_vol) begin
			if (k.up)
				n.pend = (s.pend == '1) ? s.pend : s.pend + 1'b1;	// stop at max
			else if (k.down)
				n.pend = (s.pend == '0) ? s.pend : s.pend - 1'b1;	// stop at zero
			else begin
				n.item = home;
				if (k.select)
					n.vol = s.pend;	// left throws pend away
			end
		end else if (|k) begin
			case (s.st)
				initialize: if (k.select) begin
					n.st = idle;
					n.item = def_welcome;
				end
				idle: begin
					if (k.up || k.down)
						n.item = rotate(s.item, k.down, 4, call_number, volume, get_num, set_time);
					else if (k.select && (s.item == def_welcome || s.item == def_sys))
						n.item = call_number;
					else if (k.select && s.item == call_number)
						n.item = dialing;
					else if (k.select && s.item == volume) begin
						n.pend = s.vol;
						n.item = change_vol;
					end else if (k.select && s.item == dialing) begin
						n.addr = sw;
						n.cmd = make_call;
						n.st = outgoing;
						n.item = def_outgoing;
					end else if (k.left && s.item == dialing)
						n.item = call_number;
					else if (k.left && rotate(s.item, 1'b1, 4, call_number, volume, get_num,
							set_time) != s.item)
						n.item = def_sys;
				end
				outgoing: begin
					if (k.up || k.down)
						n.item = rotate(s.item, k.down, 2, def_outgoing, end_call, end_call,
							end_call);
					else if (k.select && s.item == end_call)
						n.cmd = stop_call;
				end
				incoming: begin
					if (k.up || k.down)
						n.item = rotate(s.item, k.down, 3, def_incoming, accept, reject, reject);
					else if (k.select && s.item == reject)
						n.cmd = stop_call;
					else if (k.select)
						n.cmd = accept_call;
				end
				busy: begin
					if (k.up || k.down)
						n.item = rotate(s.item, k.down, 3, def_busy, end_call_b, set_volume,
							set_volume);
					else if (k.select && s.item == end_call_b)
						n.cmd = stop_call;
					else if (k.select && s.item == set_volume) begin
						n.pend = s.vol;
						n.item = change_vol;
					end
				end
				default: ;
			endcase
		end else if (s.st == idle && a == incoming_call) begin
			n.st = incoming;
			n.item = def_incoming;
		end else if ((s.st == outgoing || s.st == incoming) && a == connected) begin
			n.st = busy;
			n.item = def_busy;
		end else if ((s.st != idle && s.st != initialize && a == call_ended) ||
				(s.st == outgoing && a == failed)) begin
			n.st = idle;	// call is over
			n.item = def_sys;
		end
		return n;
	endfunction

	task automatic check_value(input string name, input int got, input int want);
		if (got != want) begin
			value_errors++;
			$display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, want);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// compare on every edge, values seen here are from before the edge
	////////////////////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		if (reset) begin
			m = '{st: initialize, item: def_init, cmd: cmd_init, addr: '0,
				vol: vol_mid, pend: vol_mid};
			evt = '0;
			cur = '0;
			prev = '0;
			t_prev = def_init;
			exp_addr = 11'd0;	// banner
			exp_len = 11'd45;
			exp_start = 1'b0;
		end else begin
			check_value("current_state", current_state, m.st);
			check_value("current_menu_item", current_menu_item, m.item);
			check_value("command", command, m.cmd);
			check_value("address", address, m.addr);
			check_value("headphone_volume", headphone_volume, m.vol);
			check_value("text_addr", text_addr, exp_addr);
			check_value("text_len", text_len, exp_len);
			check_value("text_start", text_start, exp_start);
			// stage 3 sees the item stage 2 shows now
			t = expected_text(m.item);
			exp_start = 1'b0;
			if (m.item != t_prev && t.has_text) begin
				exp_addr = t.addr;
				exp_len = t.len;
				exp_start = 1'b1;
			end
			t_prev = m.item;
			m = step(m, evt, inc_command, switches);
			// stage 1, rising edges with up > down > select > left
			rise = cur & ~prev;
			evt = {rise[0], rise[1] & ~rise[0], (rise[2] | rise[3]) & ~|rise[1:0],
				rise[4] & ~|rise[3:0]};
			prev = cur;
			cur = buttons;
		end
	end

endmodule

/* tb_user_interface.sv */
`timescale 1ns/10ps

module tb_user_interface import ui_pkg::*;;

	localparam int NUM_W = 8;
	localparam int VOL_W = 5;

	logic                   clk;
	logic                   reset;
	logic [4:0]             btn;	// left, right, enter, down, up
	logic [NUM_W-1:0]       switches;
	app_status_t            inc_command;
	call_state_t            current_state;
	menu_item_t             current_menu_item;
	ui_cmd_t                command;
	logic [NUM_W-1:0]       address;
	logic [VOL_W-1:0]       headphone_volume;
	logic [TEXT_ADDR_W-1:0] text_addr;
	logic [TEXT_ADDR_W-1:0] text_len;
	logic                   text_start;
	int                     value_errors;
	int                     timeouts;
	logic [31:0]            lfsr;

	user_interface #(.NUM_W(NUM_W), .VOL_W(VOL_W)) u_user_interface (
		.clk(clk), .reset(reset), .enter(btn[2]), .up(btn[0]), .down(btn[1]),
		.left(btn[4]), .right(btn[3]), .switches(switches), .inc_command(inc_command),
		.current_state(current_state), .current_menu_item(current_menu_item),
		.command(command), .address(address), .headphone_volume(headphone_volume),
		.text_addr(text_addr), .text_len(text_len), .text_start(text_start)
	);

	ui_checker #(.NUM_W(NUM_W), .VOL_W(VOL_W)) u_ui_checker (
		.clk(clk), .reset(reset), .buttons(btn), .switches(switches),
		.inc_command(inc_command), .current_state(current_state),
		.current_menu_item(current_menu_item), .command(command), .address(address),
		.headphone_volume(headphone_volume), .text_addr(text_addr), .text_len(text_len),
		.text_start(text_start), .value_errors(value_errors)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// 100 ns
	end

	// galois form, taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] galois_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic draw(input int nbits, output int v);
		v = 0;
		for (int i = 0; i < nbits; i++) begin
			lfsr = galois_step(lfsr);	// one step per bit
			v = (v << 1) | lfsr[0];
		end
	endtask

	// 0 up, 1 down, 2 enter, 3 right, 4 left
	task automatic press(input int which, input int hold);
		@(posedge clk);
		btn <= 5'b1 << which;
		repeat (hold) @(posedge clk);
		btn <= '0;
		repeat (3) @(posedge clk);	// sample, event, fsm
	endtask

	task automatic send_status(input app_status_t s);
		@(posedge clk);
		inc_command <= s;
		@(posedge clk);
		inc_command <= sts_none;
	endtask

	task automatic wait_for(input call_state_t s, input menu_item_t item);
		int n;
		n = 0;
		do begin
			@(negedge clk);	// outputs settled
			n++;
		end while ((current_state !== s || current_menu_item !== item) && n < 20);
		if (current_state !== s || current_menu_item !== item) begin
			timeouts++;
			$display("timeout at %0t: state %0d with menu item %0d never showed up",
				$time, s, item);
		end
	endtask

	initial begin
		int n;
		int v;
		btn = '0;
		switches = '0;
		inc_command = sts_none;
		reset = 1'b1;
		timeouts = 0;
		lfsr = 32'h963b;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		////////////////////////////////////////////////////////////////////////////
		// banner, welcome, main ring
		////////////////////////////////////////////////////////////////////////////
		press(2, 1);
		wait_for(idle, def_welcome);
		press(3, 1);	// right is select too
		draw(3, n);
		repeat (n) press(0, 1);
		draw(3, n);
		repeat (n) press(1, 1);
		press(1, 4);	// held, one step only
		press(4, 1);
		wait_for(idle, def_sys);
		// outgoing, first connected then failed
		for (int k = 0; k < 2; k++) begin
			press(2, 1);
			press(2, 1);
			draw(NUM_W, v);
			@(posedge clk);
			switches <= v[NUM_W-1:0];
			press(2, 1);
			wait_for(outgoing, def_outgoing);
			if (k == 0) begin
				send_status(connected);
				wait_for(busy, def_busy);
				press(1, 1);	// end_call_b
				press(2, 1);
				send_status(call_ended);
			end else begin
				press(1, 1);
				press(0, 1);
				send_status(failed);
			end
			wait_for(idle, def_sys);
		end
		// incoming, first accepted then rejected
		for (int k = 0; k < 2; k++) begin
			send_status(incoming_call);
			wait_for(incoming, def_incoming);
			press(k == 0 ? 1 : 0, 1);
			press(2, 1);
			if (k == 0) begin
				send_status(connected);
				wait_for(busy, def_busy);
			end
			send_status(call_ended);
			wait_for(idle, def_sys);
		end
		////////////////////////////////////////////////////////////////////////////
		// volume, idle then busy
		////////////////////////////////////////////////////////////////////////////
		press(2, 1);
		press(1, 1);
		press(2, 1);
		wait_for(idle, change_vol);
		draw(4, n);
		repeat (16 + n) press(0, 1);	// past the top
		press(2, 1);	// commit the top value
		press(2, 1);
		draw(3, n);
		repeat (31 + n) press(1, 1);	// past the bottom
		draw(4, n);
		repeat (n) press(0, 1);
		press(2, 1);
		wait_for(idle, volume);
		press(2, 1);
		draw(3, n);
		repeat (n + 1) press(0, 1);
		press(4, 1);	// discard
		wait_for(idle, volume);
		send_status(incoming_call);
		wait_for(incoming, def_incoming);
		press(2, 1);
		send_status(connected);
		wait_for(busy, def_busy);
		press(0, 1);	// set_volume
		press(2, 1);
		draw(5, n);
		repeat (n) press(1, 1);
		draw(5, n);
		repeat (n) press(0, 1);
		press(2, 1);
		wait_for(busy, set_volume);
		press(2, 1);
		press(1, 1);
		press(4, 1);
		wait_for(busy, set_volume);
		send_status(call_ended);
		wait_for(idle, def_sys);
		repeat (3) @(posedge clk);
		$display("errors: %0d wrong values, %0d timeouts", value_errors, timeouts);
		if (value_errors == 0 && timeouts == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* compile.f */
ui_pkg.sv
key_sampler.sv
call_menu_fsm.sv
menu_text_rom.sv
user_interface.sv
ui_checker.sv
tb_user_interface.sv

/* Bender.yml */
package:
  name: user_interface

sources:
  - ui_pkg.sv
  - key_sampler.sv
  - call_menu_fsm.sv
  - menu_text_rom.sv
  - user_interface.sv
  - target: test
    files:
      - ui_checker.sv
      - tb_user_interface.sv
